// File: logic/calc_pkg.sv
`default_nettype none

package calc_pkg;

    // keypad
    localparam int KEY_W = 4;                          // key index and digit width

    // scan timing, sized so the counters in the scanner take their width
    localparam logic [1:0] COL_SETTLE = 2'd3;          // cycles per column before sampling
    localparam logic [3:0] DEBOUNCE_CYCLES = 4'd10;    // stable cycles to accept a press

    // arithmetic
    localparam int DATA_W = 16;                        // signed operand and result width
    localparam int OP_W = 3;                           // operator code width

    // operator codes shared by scanner, controller and alu
    typedef enum logic [OP_W-1:0] {
        OP_NONE = 3'd0,                                // plain digit or equals
        OP_NEG  = 3'd1,                                // sign change key
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_t;

    // keypad scanner FSM
    typedef enum logic [2:0] {
        IDLE,
        SCAN_COL,                                      // stepping columns
        WAIT_STABLE,                                   // debouncing
        CONFIRM,                                       // key offered to controller
        WAIT_RELEASE
    } scan_state_t;

    // calculator controller FSM
    typedef enum logic [1:0] {
        ENTRY_A,                                       // building first operand
        ENTRY_B,                                       // building second operand
        COMPUTE,                                       // alu busy
        SHOW                                           // result on display
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/input_control.sv
`timescale 1ns/1ps
`default_nettype none

module input_control (
    input  logic                       clk,
    input  logic                       nRST,            // async, active low
    input  logic [3:0]                 row_in,          // rows, pulled up
    output logic [3:0]                 col_out,         // one column low at a time
    output logic                       read_input,      // key waiting for controller
    input  logic                       key_read,        // ack pulse from controller
    output logic [calc_pkg::KEY_W-1:0] keypad_input,    // digit 0..9
    output calc_pkg::op_t              operator_input,  // operator or sign key
    output logic                       equal_input      // equals key
);

    calc_pkg::scan_state_t state, next_state;

    logic [3:0] row_mid, row_sync;                                // two stage sync
    logic [1:0] col_index;                                        // driven column
    logic [$bits(calc_pkg::COL_SETTLE)-1:0]      settle_cnt;
    logic [$bits(calc_pkg::DEBOUNCE_CYCLES)-1:0] debounce_cnt;
    logic key_valid;                                              // some row low
    logic settled;                                                // column held long enough
    logic stable;                                                 // press held long enough
    logic load_key;                                               // entering CONFIRM

    logic [calc_pkg::KEY_W-1:0] key_idx;                          // row*4 + col
    logic [calc_pkg::KEY_W-1:0] dec_digit;
    calc_pkg::op_t              dec_op;
    logic                       dec_equal;

    // row index and column to key index, lowest row wins
    function automatic logic [calc_pkg::KEY_W-1:0] encode_key(
        input logic [3:0] row,
        input logic [1:0] col
    );
        logic [calc_pkg::KEY_W-1:0] idx;
        idx = 4'd14;                                              // no row, empty key
        for (int r = 3; r >= 0; r--) begin
            if (!row[r]) begin
                idx = {r[1:0], col};                              // later (lower) row overrides
            end
        end
        return idx;
    endfunction

    // rows idle high
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            row_mid  <= 4'hF;
            row_sync <= 4'hF;
        end else begin
            row_mid  <= row_in;
            row_sync <= row_mid;
        end
    end

    assign key_valid = ~&row_sync;
    assign settled   = (settle_cnt == calc_pkg::COL_SETTLE - 2'd1);
    assign stable    = (debounce_cnt == calc_pkg::DEBOUNCE_CYCLES - 4'd1);
    assign key_idx   = encode_key(row_sync, col_index);
    assign load_key  = (state == calc_pkg::WAIT_STABLE) && (next_state == calc_pkg::CONFIRM);

    always_comb begin
        next_state = state;
        case (state)
            calc_pkg::IDLE:         next_state = calc_pkg::SCAN_COL;
            calc_pkg::SCAN_COL:     if (settled && key_valid) next_state = calc_pkg::WAIT_STABLE;
            calc_pkg::WAIT_STABLE: begin
                if (!key_valid) begin
                    next_state = calc_pkg::SCAN_COL;              // bounce, rescan this column
                end else if (stable) begin
                    next_state = calc_pkg::CONFIRM;
                end
            end
            calc_pkg::CONFIRM:      if (!read_input || key_read) next_state = calc_pkg::WAIT_RELEASE;
            calc_pkg::WAIT_RELEASE: if (!key_valid) next_state = calc_pkg::IDLE;
            default:                next_state = calc_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state        <= calc_pkg::IDLE;
            col_index    <= 2'd0;
            settle_cnt   <= '0;
            debounce_cnt <= '0;
            read_input   <= 1'b0;
        end else begin
            state <= next_state;
            case (state)
                calc_pkg::SCAN_COL: begin
                    if (settled) begin
                        settle_cnt <= '0;
                        if (!key_valid) begin
                            col_index <= col_index + 2'd1;        // wraps 3 -> 0
                        end
                    end else begin
                        settle_cnt <= settle_cnt + 1'b1;
                    end
                end
                calc_pkg::WAIT_STABLE: begin
                    if (!key_valid || stable) begin
                        debounce_cnt <= '0;
                    end else begin
                        debounce_cnt <= debounce_cnt + 1'b1;
                    end
                    if (load_key) begin
                        read_input <= (key_idx != 4'd14);         // index 14 never offered
                    end
                end
                calc_pkg::CONFIRM: begin
                    if (key_read) begin
                        read_input <= 1'b0;                       // drop the cycle after ack
                    end
                end
                default: ;
            endcase
        end
    end

    // key map
    always_comb begin
        dec_digit = '0;
        dec_op    = calc_pkg::OP_NONE;
        dec_equal = 1'b0;
        case (key_idx)
            4'd0:  dec_digit = 4'd1;
            4'd1:  dec_digit = 4'd2;
            4'd2:  dec_digit = 4'd3;
            4'd3:  dec_op    = calc_pkg::OP_ADD;
            4'd4:  dec_digit = 4'd4;
            4'd5:  dec_digit = 4'd5;
            4'd6:  dec_digit = 4'd6;
            4'd7:  dec_op    = calc_pkg::OP_SUB;
            4'd8:  dec_digit = 4'd7;
            4'd9:  dec_digit = 4'd8;
            4'd10: dec_digit = 4'd9;
            4'd11: dec_op    = calc_pkg::OP_MUL;
            4'd12: dec_equal = 1'b1;
            4'd13: dec_digit = 4'd0;
            4'd15: dec_op    = calc_pkg::OP_NEG;                  // sign change
            default: ;                                            // 14 unused
        endcase
    end

    // payload, held through CONFIRM
    always_ff @(posedge clk) begin
        if (load_key) begin
            keypad_input   <= dec_digit;
            operator_input <= dec_op;
            equal_input    <= dec_equal;
        end
    end

    always_comb begin
        col_out            = 4'b1111;
        col_out[col_index] = 1'b0;                                // active column low
    end

endmodule

`default_nettype wire

// File: logic/calc_alu.sv
`timescale 1ns/1ps
`default_nettype none

module calc_alu (
    input  logic                               clk,
    input  logic                               nRST,
    input  logic                               alu_start,    // one cycle
    input  calc_pkg::op_t                      alu_op,
    input  logic signed [calc_pkg::DATA_W-1:0] alu_a,
    input  logic signed [calc_pkg::DATA_W-1:0] alu_b,
    output logic                               alu_done,     // start delayed by one
    output logic signed [calc_pkg::DATA_W-1:0] alu_result,   // wrapped
    output logic                               alu_ovf       // exact result out of range
);

    logic signed [2*calc_pkg::DATA_W-1:0] exact;    // wide enough for the product
    logic                                 ovf_next;

    // operands sign extend to the wide context
    always_comb begin
        case (alu_op)
            calc_pkg::OP_ADD: exact = alu_a + alu_b;
            calc_pkg::OP_SUB: exact = alu_a - alu_b;
            calc_pkg::OP_MUL: exact = alu_a * alu_b;
            default:          exact = alu_a;             // pass first operand
        endcase
    end

    // upper bits must all match the result sign bit
    assign ovf_next = exact[2*calc_pkg::DATA_W-1:calc_pkg::DATA_W-1]
                      != {(calc_pkg::DATA_W+1){exact[calc_pkg::DATA_W-1]}};

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            alu_done <= 1'b0;
        end else begin
            alu_done <= alu_start;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            alu_result <= exact[calc_pkg::DATA_W-1:0];
            alu_ovf    <= ovf_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/calc_controller.sv
`timescale 1ns/1ps
`default_nettype none

module calc_controller (
    input  logic                              clk,
    input  logic                              nRST,
    input  logic                              read_input,      // key offered
    input  logic [calc_pkg::KEY_W-1:0]        keypad_input,
    input  calc_pkg::op_t                     operator_input,
    input  logic                              equal_input,
    output logic                              key_read,        // one cycle ack
    output logic                              alu_start,
    output calc_pkg::op_t                     alu_op,
    output logic signed [calc_pkg::DATA_W-1:0] alu_a,
    output logic signed [calc_pkg::DATA_W-1:0] alu_b,
    input  logic                              alu_done,
    input  logic signed [calc_pkg::DATA_W-1:0] alu_result,
    input  logic                              alu_ovf,
    output logic signed [calc_pkg::DATA_W-1:0] result,
    output logic                              result_valid,    // one cycle pulse
    output logic                              overflow
);

    calc_pkg::ctrl_state_t state;

    logic signed [calc_pkg::DATA_W-1:0] entry_a;      // first operand, or last result
    logic signed [calc_pkg::DATA_W-1:0] entry_b;
    logic signed [calc_pkg::DATA_W-1:0] digit_ext;    // zero extended digit
    calc_pkg::op_t                      pend_op;      // operator waiting for equals
    logic                               take_key;

    // decimal shift in, wraps at DATA_W
    function automatic logic signed [calc_pkg::DATA_W-1:0] shift_in(
        input logic signed [calc_pkg::DATA_W-1:0] entry,
        input logic signed [calc_pkg::DATA_W-1:0] digit
    );
        return entry * 16'sd10 + digit;
    endfunction

    // first cycle of read_input, held off while alu busy
    assign take_key  = read_input && !key_read && (state != calc_pkg::COMPUTE);
    assign digit_ext = $signed({{(calc_pkg::DATA_W-calc_pkg::KEY_W){1'b0}}, keypad_input});

    assign alu_a  = entry_a;
    assign alu_b  = entry_b;
    assign alu_op = pend_op;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state        <= calc_pkg::ENTRY_A;
            entry_a      <= '0;
            entry_b      <= '0;
            pend_op      <= calc_pkg::OP_NONE;
            key_read     <= 1'b0;
            alu_start    <= 1'b0;
            result       <= '0;
            result_valid <= 1'b0;
            overflow     <= 1'b0;
        end else begin
            key_read     <= take_key;
            alu_start    <= 1'b0;
            result_valid <= 1'b0;

            if (take_key) begin
                if (equal_input) begin
                    if (state == calc_pkg::ENTRY_B) begin     // ignored elsewhere
                        alu_start <= 1'b1;
                        state     <= calc_pkg::COMPUTE;
                    end
                end else if (operator_input == calc_pkg::OP_NEG) begin
                    if (state == calc_pkg::ENTRY_B) begin
                        entry_b <= -entry_b;
                    end else begin
                        entry_a <= -entry_a;                  // after SHOW, negates result
                        state   <= calc_pkg::ENTRY_A;
                    end
                end else if (operator_input != calc_pkg::OP_NONE) begin
                    pend_op <= operator_input;                // replaces pending op in ENTRY_B
                    if (state != calc_pkg::ENTRY_B) begin
                        entry_b <= '0;
                        state   <= calc_pkg::ENTRY_B;         // from SHOW keeps result as A
                    end
                end else begin
                    case (state)
                        calc_pkg::ENTRY_B: entry_b <= shift_in(entry_b, digit_ext);
                        calc_pkg::SHOW: begin
                            entry_a <= digit_ext;             // fresh first operand
                            state   <= calc_pkg::ENTRY_A;
                        end
                        default:           entry_a <= shift_in(entry_a, digit_ext);
                    endcase
                end
            end

            if ((state == calc_pkg::COMPUTE) && alu_done) begin
                result       <= alu_result;
                overflow     <= alu_ovf;
                result_valid <= 1'b1;
                entry_a      <= alu_result;                   // chain from shown value
                state        <= calc_pkg::SHOW;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/keypad_calc_top.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_calc_top (
    input  logic                               clk,
    input  logic                               nRST,
    input  logic [3:0]                         row_in,        // active low, pulled up
    output logic [3:0]                         col_out,       // scanned column low
    output logic signed [calc_pkg::DATA_W-1:0] result,
    output logic                               result_valid,
    output logic                               overflow
);

    // scanner to controller
    logic                       read_input;
    logic                       key_read;
    logic [calc_pkg::KEY_W-1:0] keypad_input;
    calc_pkg::op_t              operator_input;
    logic                       equal_input;

    // controller to alu and back
    logic                               alu_start;
    calc_pkg::op_t                      alu_op;
    logic signed [calc_pkg::DATA_W-1:0] alu_a, alu_b;
    logic                               alu_done;
    logic signed [calc_pkg::DATA_W-1:0] alu_result;
    logic                               alu_ovf;

    input_control u_input_control (
        .clk, .nRST, .row_in, .col_out,
        .read_input, .key_read,
        .keypad_input, .operator_input, .equal_input
    );

    calc_controller u_calc_controller (
        .clk, .nRST,
        .read_input, .keypad_input, .operator_input, .equal_input, .key_read,
        .alu_start, .alu_op, .alu_a, .alu_b,
        .alu_done, .alu_result, .alu_ovf,
        .result, .result_valid, .overflow
    );

    calc_alu u_calc_alu (
        .clk, .nRST,
        .alu_start, .alu_op, .alu_a, .alu_b,
        .alu_done, .alu_result, .alu_ovf
    );

endmodule

`default_nettype wire

// File: tests/keypad_calc_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_calc_assertions (
    input logic                       clk,
    input logic                       nRST,
    input logic [3:0]                 col_out,
    input logic                       read_input,
    input logic                       key_read,
    input logic [calc_pkg::KEY_W-1:0] keypad_input,
    input calc_pkg::op_t              operator_input,
    input logic                       equal_input
);

    // exactly one column driven low
    col_one_cold: assert property (@(posedge clk) disable iff (!nRST)
        $onehot(~col_out))
        else $error("col_out is not one-cold: %b", col_out);

    // payload frozen until the controller acks
    payload_stable: assert property (@(posedge clk) disable iff (!nRST)
        read_input && !key_read |=> $stable({keypad_input, operator_input, equal_input}))
        else $error("key payload changed while read_input waits for key_read");

    read_drops_after_ack: assert property (@(posedge clk) disable iff (!nRST)
        key_read |=> !read_input)
        else $error("read_input still high the cycle after key_read");

endmodule

bind input_control keypad_calc_assertions u_scan_assertions (.*);

`default_nettype wire

// File: tests/keypad_calc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_calc_tb;

    localparam int GAP_CYCLES  = 20;              // release gap, longer than debounce
    localparam int MAX_EXTRA   = 5;               // random hold padding
    localparam int RESULT_WAIT = 50;              // cycles allowed for a late result

    logic               clk;
    logic               nRST;
    logic [3:0]         row_in;
    logic [3:0]         col_out;
    logic signed [15:0] result;
    logic               result_valid;
    logic               overflow;

    logic               key_down;                 // keypad model
    logic [3:0]         key_idx;

    byte  kind_q[$];                              // P press, E expect
    int   arg1_q[$];
    int   arg2_q[$];
    int   seen_res_q[$];                          // captured from dut
    logic seen_ovf_q[$];
    int   model_res_q[$];                         // predicted from key rules
    logic model_ovf_q[$];

    int m_a, m_b, m_op, m_state;                  // state 0 entry a, 1 entry b, 2 shown
    int errors, checks;
    int wd_cycles;
    int ack_count;                                // key_read pulses seen so far

    keypad_calc_top dut (.clk, .nRST, .row_in, .col_out, .result, .result_valid, .overflow);

    always #20 clk = ~clk;                        // 40 ns period

    // pressed key pulls its row low while its column is scanned
    always @(negedge clk) begin
        if (key_down && !col_out[key_idx[1:0]]) begin
            row_in <= ~(4'b0001 << key_idx[3:2]);
        end else begin
            row_in <= 4'hF;                       // pull ups
        end
    end

    always @(negedge clk) begin
        if (result_valid) begin
            seen_res_q.push_back(result);         // one entry per pulse
            seen_ovf_q.push_back(overflow);
        end
    end

    // count controller acks
    always @(posedge clk) begin
        if (dut.key_read) begin
            ack_count++;
        end
    end

    function automatic int wrap16(input longint v);
        logic signed [15:0] w;
        w = v[15:0];                              // keep low 16 bits, sign extend
        return w;
    endfunction

    function automatic int key_digit(input int idx);
        case (idx)
            0, 1, 2:  return idx + 1;
            4, 5, 6:  return idx;
            8, 9, 10: return idx - 1;
            13:       return 0;
            default:  return -1;                  // not a digit key
        endcase
    endfunction

    // calculator rules, applied per press
    task automatic apply_key(input int idx);
        int     d;
        longint exact;
        d = key_digit(idx);
        if (idx == 12) begin
            if (m_state == 1) begin               // equals only counts in entry b
                case (m_op)
                    3:       exact = longint'(m_a) + m_b;
                    7:       exact = longint'(m_a) - m_b;
                    default: exact = longint'(m_a) * m_b;
                endcase
                model_res_q.push_back(wrap16(exact));
                model_ovf_q.push_back(exact > 32767 || exact < -32768);
                m_a     = wrap16(exact);          // chained operand
                m_state = 2;
            end
        end else if (idx == 15) begin
            if (m_state == 1) begin
                m_b = wrap16(-m_b);
            end else begin
                m_a     = wrap16(-m_a);
                m_state = 0;
            end
        end else if (d >= 0) begin
            if (m_state == 1) begin
                m_b = wrap16(longint'(m_b) * 10 + d);
            end else if (m_state == 2) begin
                m_a     = d;                      // new first operand
                m_state = 0;
            end else begin
                m_a = wrap16(longint'(m_a) * 10 + d);
            end
        end else if (idx != 14) begin
            m_op = idx;                           // add, sub or mul key
            if (m_state != 1) begin
                m_b     = 0;
                m_state = 1;
            end
        end
    endtask

    task automatic press_key(input int idx, input int hold);
        int extra;
        int acks;
        int exp_acks;
        extra    = $urandom % (MAX_EXTRA + 1);
        exp_acks = (idx == 14) ? 0 : 1;           // unused key gives no strobe
        @(negedge clk);
        acks     = ack_count;
        key_idx  <= idx[3:0];
        key_down <= 1'b1;
        apply_key(idx);
        repeat (hold + extra) @(negedge clk);
        key_down <= 1'b0;                         // release
        repeat (GAP_CYCLES) @(negedge clk);
        checks++;
        assert (ack_count - acks == exp_acks) else begin
            errors++;
            $display("** Error at %0d ns: key %0d acknowledged %0d times, expected %0d",
                     $time, idx, ack_count - acks, exp_acks);
        end
    endtask

    task automatic check_result(input int exp_res, input int exp_ovf);
        int   w;
        int   res;
        logic ovf;
        checks++;
        assert (model_res_q.size() != 0) else begin
            errors++;
            $display("data file expects a result that its key sequence does not produce");
        end
        if (model_res_q.size() != 0) begin
            res = model_res_q.pop_front();
            ovf = model_ovf_q.pop_front();
            assert (res == exp_res && ovf == exp_ovf[0]) else begin
                errors++;
                $display("** Error at %0d ns: data file has %0d ovf %0d, rules give %0d ovf %0d",
                         $time, exp_res, exp_ovf, res, ovf);
            end
        end
        w = 0;
        while (seen_res_q.size() == 0 && w < RESULT_WAIT) begin
            @(posedge clk);
            w++;
        end
        checks++;
        assert (seen_res_q.size() != 0) else begin
            errors++;
            $display("no result_valid within %0d cycles, expected %0d", RESULT_WAIT, exp_res);
        end
        if (seen_res_q.size() != 0) begin
            res = seen_res_q.pop_front();
            ovf = seen_ovf_q.pop_front();
            assert (res == exp_res && ovf == exp_ovf[0]) else begin
                errors++;
                $display("** Error at %0d ns: result %0d ovf %0d, expected %0d ovf %0d",
                         $time, res, ovf, exp_res, exp_ovf);
            end
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        byte   kind;
        int    v1, v2;
        int    total;
        string line;
        total = 0;
        fd = $fopen("tests/keypad_calc_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open tests/keypad_calc_testdata.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%c %d %d", kind, v1, v2);
                if (n == 3 && (kind == "P" || kind == "E")) begin    // comments skipped
                    kind_q.push_back(kind);
                    arg1_q.push_back(v1);
                    arg2_q.push_back(v2);
                    if (kind == "P") begin
                        total += 2 * (v2 + MAX_EXTRA + GAP_CYCLES + 1);
                    end
                end
            end
            $fclose(fd);
            wd_cycles = total + 16;               // reset and settle
        end
    endtask

    initial begin
        clk       = 1'b0;
        nRST      = 1'b0;
        row_in    = 4'hF;
        key_down  = 1'b0;
        key_idx   = 4'd0;
        errors    = 0;
        checks    = 0;
        wd_cycles = 0;
        ack_count = 0;
        m_a       = 0;
        m_b       = 0;
        m_op      = 0;
        m_state   = 0;
        void'($urandom(32'hc653_d248));
        load_vectors();
        repeat (4) @(negedge clk);
        nRST = 1'b1;
        repeat (4) @(negedge clk);
        foreach (kind_q[i]) begin
            if (kind_q[i] == "P") begin
                press_key(arg1_q[i], arg2_q[i]);
            end else begin
                check_result(arg1_q[i], arg2_q[i]);
            end
        end
        // an ignored equals must leave nothing behind
        checks++;
        assert (seen_res_q.size() == 0 && model_res_q.size() == 0) else begin
            errors++;
            $display("unexpected results left over: %0d from the dut, %0d from the rules",
                     seen_res_q.size(), model_res_q.size());
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not complete", wd_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/keypad_calc_testdata.txt
# P <key index> <hold cycles>   press one key and hold it
# E <result> <overflow>         next result and its overflow flag
P 12 40   equals in entry a, ignored
P 0 40
P 1 40
P 3 40
P 2 40
P 4 40
P 12 40
E 46 0
P 7 200   long hold, counts once
P 6 40
P 12 40
E 40 0
P 9 40
P 12 40   ignored again
P 11 40
P 1 40
P 12 40
E 16 0
P 5 40
P 7 40
P 10 40
P 12 40
E -4 0
P 8 40
P 15 40   minus sign
P 11 40
P 2 40
P 12 40
E -21 0
P 2 40
P 13 40
P 13 40
P 11 40
P 1 40
P 13 40
P 13 40
P 12 40
E -5536 1
P 10 40
P 14 40   unused key
P 13 40
P 3 40
P 0 40
P 12 40
E 91 0

// File: project.f
logic/calc_pkg.sv
logic/input_control.sv
logic/calc_alu.sv
logic/calc_controller.sv
logic/keypad_calc_top.sv
tests/keypad_calc_assertions.sv
tests/keypad_calc_tb.sv

// File: Bender.yml
package:
  name: keypad_calc

sources:
  - logic/calc_pkg.sv
  - logic/input_control.sv
  - logic/calc_alu.sv
  - logic/calc_controller.sv
  - logic/keypad_calc_top.sv
  - target: test
    files:
      - tests/keypad_calc_assertions.sv
      - tests/keypad_calc_tb.sv
